//--- verilog/snd_pkg.sv
// Sound path constants and types; sample width fixed at 16 bits, level at 20 bits, one clock domain
`default_nettype none

package snd_pkg;

    // Game sample and modulator level widths
    localparam int SND_W = 16;
    localparam int PCM_W = 20;

    // clk_dac cycles per modulator update
    localparam int CEN_DIV = 4;

    // One channel sample as delivered by the game core
    typedef logic [SND_W-1:0] snd_sample_t;

    // Unsigned level fed to the modulator
    typedef logic [PCM_W-1:0] pcm_word_t;

    // Sample coding, chosen per transfer
    typedef enum logic {
        FMT_UNSIGNED = 1'b0,
        FMT_SIGNED   = 1'b1
    } snd_fmt_e;

    // Four-phase handshake on the input side
    typedef enum logic [1:0] {
        HS_IDLE     = 2'd0,
        HS_ACK      = 2'd1,
        HS_WAIT_LOW = 2'd2
    } hs_state_e;

endpackage

`default_nettype wire

//--- verilog/snd_sample_in.sv
// Four-phase input; req_i may be asynchronous, data and fmt_i must be stable while req_i is high
`timescale 1ns/1ps
`default_nettype none

module snd_sample_in (
    input  wire                  clk_dac,
    input  wire                  rst,
    input  wire                  req_i,
    input  wire snd_pkg::snd_sample_t snd_left_i,
    input  wire snd_pkg::snd_sample_t snd_right_i,
    input  wire snd_pkg::snd_fmt_e    fmt_i,
    output logic                 ack_o,
    output logic                 new_o,
    output snd_pkg::snd_sample_t left_o,
    output snd_pkg::snd_sample_t right_o,
    output snd_pkg::snd_fmt_e    fmt_o
);

    import snd_pkg::*;

    logic        req_s1;
    logic        req_s2;
    hs_state_e   state_q;
    snd_sample_t left_q;
    snd_sample_t right_q;
    snd_fmt_e    fmt_q;

    // Two-flop synchronizer for the request
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            req_s1 <= 1'b0;
            req_s2 <= 1'b0;
        end else begin
            req_s1 <= req_i;
            req_s2 <= req_s1;
        end
    end

    // Handshake FSM and one-shot new sample strobe
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            state_q <= HS_IDLE;
            new_o   <= 1'b0;
        end else begin
            new_o <= 1'b0;
            case (state_q)
                HS_IDLE: begin
                    if (req_s2) begin
                        state_q <= HS_ACK;
                        new_o   <= 1'b1;
                    end
                end
                HS_ACK: begin
                    // Hold ack until the producer drops req
                    if (!req_s2) begin
                        state_q <= HS_WAIT_LOW;
                    end
                end
                HS_WAIT_LOW: begin
                    // Ack is already low here, one guard cycle before rearming
                    if (!req_s2) begin
                        state_q <= HS_IDLE;
                    end
                end
                default: begin
                    state_q <= HS_IDLE;
                end
            endcase
        end
    end

    // Sample pair is taken when leaving idle
    always_ff @(posedge clk_dac) begin
        if (state_q == HS_IDLE && req_s2) begin
            left_q  <= snd_left_i;
            right_q <= snd_right_i;
            fmt_q   <= fmt_i;
        end
    end

    assign ack_o   = (state_q == HS_ACK);
    assign left_o  = left_q;
    assign right_o = right_q;
    assign fmt_o   = fmt_q;

endmodule

`default_nettype wire

//--- verilog/snd_pcm_stage.sv
// Converts captured pairs to 20-bit levels; both channels switch together on the next update enable
`timescale 1ns/1ps
`default_nettype none

module snd_pcm_stage (
    input  wire                       clk_dac,
    input  wire                       rst,
    input  wire                       new_i,
    input  wire snd_pkg::snd_sample_t left_i,
    input  wire snd_pkg::snd_sample_t right_i,
    input  wire snd_pkg::snd_fmt_e    fmt_i,
    output logic                      cen_o,
    output snd_pkg::pcm_word_t        pcm_left_o,
    output snd_pkg::pcm_word_t        pcm_right_o
);

    import snd_pkg::*;

    logic [CEN_DIV-1:0] cen_ring;
    pcm_word_t          pend_left;
    pcm_word_t          pend_right;
    logic               pend_vld;
    pcm_word_t          act_left;
    pcm_word_t          act_right;

    // Flip the sign bit for two's complement input, then pad to the level width
    function automatic pcm_word_t to_pcm(input snd_sample_t smp, input snd_fmt_e fmt);
        snd_sample_t adj;
        adj = {smp[SND_W-1] ^ (fmt == FMT_SIGNED), smp[SND_W-2:0]};
        return {1'b0, adj, 3'b000};
    endfunction

    // Rotating one-hot enable, first pulse on the third cycle after reset
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            cen_ring <= CEN_DIV'(3'b100);
        end else begin
            cen_ring <= {cen_ring[CEN_DIV-2:0], cen_ring[CEN_DIV-1]};
        end
    end

    assign cen_o = cen_ring[0];

    // Pending pair waits for the next update
    always_ff @(posedge clk_dac) begin
        if (new_i) begin
            pend_left  <= to_pcm(left_i, fmt_i);
            pend_right <= to_pcm(right_i, fmt_i);
        end
    end

    // New data wins over a transfer in the same cycle
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            pend_vld <= 1'b0;
        end else if (new_i) begin
            pend_vld <= 1'b1;
        end else if (cen_o) begin
            pend_vld <= 1'b0;
        end
    end

    // Active levels seen by the modulators
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            act_left  <= '0;
            act_right <= '0;
        end else if (cen_o && pend_vld) begin
            act_left  <= pend_left;
            act_right <= pend_right;
        end
    end

    assign pcm_left_o  = act_left;
    assign pcm_right_o = act_right;

endmodule

`default_nettype wire

//--- verilog/snd_sigma_delta.sv
// First-order 1-bit modulator; density is pcm_i over 2^20 per enabled update
`timescale 1ns/1ps
`default_nettype none

module snd_sigma_delta (
    input  wire                     clk_dac,
    input  wire                     rst,
    input  wire                     cen_i,
    input  wire snd_pkg::pcm_word_t pcm_i,
    output logic                    bit_o
);

    import snd_pkg::*;

    pcm_word_t        acc_q;
    logic [PCM_W:0]   sum;
    logic             bit_q;

    // Extra bit holds the carry
    assign sum = {1'b0, acc_q} + {1'b0, pcm_i};

    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            acc_q <= '0;
            bit_q <= 1'b0;
        end else if (cen_i) begin
            // Keep the residue, emit the overflow
            acc_q <= sum[PCM_W-1:0];
            bit_q <= sum[PCM_W];
        end
    end

    assign bit_o = bit_q;

endmodule

`default_nettype wire

//--- verilog/snd_dac_out.sv
// Pin register stage; stereo_i is expected to be static while sound plays
`timescale 1ns/1ps
`default_nettype none

module snd_dac_out (
    input  wire  clk_dac,
    input  wire  rst,
    input  wire  stereo_i,
    input  wire  bit_left_i,
    input  wire  bit_right_i,
    output logic pwm_left_o,
    output logic pwm_right_o
);

    logic left_q;
    logic right_q;

    // Mono routing happens ahead of the flops so both pins come straight from registers
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            left_q  <= 1'b0;
            right_q <= 1'b0;
        end else begin
            left_q  <= bit_left_i;
            right_q <= stereo_i ? bit_right_i : bit_left_i;
        end
    end

    assign pwm_left_o  = left_q;
    assign pwm_right_o = right_q;

endmodule

`default_nettype wire

//--- verilog/snd_dac_top.sv
// Stereo pulse-density sound output; single clk_dac domain, game side uses a four-phase req/ack
`timescale 1ns/1ps
`default_nettype none

module snd_dac_top (
    input  wire                       clk_dac,
    input  wire                       rst,
    input  wire                       req_i,
    output logic                      ack_o,
    input  wire snd_pkg::snd_sample_t snd_left_i,
    input  wire snd_pkg::snd_sample_t snd_right_i,
    input  wire snd_pkg::snd_fmt_e    fmt_i,
    input  wire                       stereo_i,
    output logic                      pwm_left_o,
    output logic                      pwm_right_o
);

    import snd_pkg::*;

    logic        new_pulse;
    snd_sample_t cap_left;
    snd_sample_t cap_right;
    snd_fmt_e    cap_fmt;
    logic        cen;
    pcm_word_t   pcm_left;
    pcm_word_t   pcm_right;
    logic        bit_left;
    logic        bit_right;

    snd_sample_in u_sample_in (
        .clk_dac     ( clk_dac     ),
        .rst         ( rst         ),
        .req_i       ( req_i       ),
        .snd_left_i  ( snd_left_i  ),
        .snd_right_i ( snd_right_i ),
        .fmt_i       ( fmt_i       ),
        .ack_o       ( ack_o       ),
        .new_o       ( new_pulse   ),
        .left_o      ( cap_left    ),
        .right_o     ( cap_right   ),
        .fmt_o       ( cap_fmt     )
    );

    snd_pcm_stage u_pcm_stage (
        .clk_dac     ( clk_dac     ),
        .rst         ( rst         ),
        .new_i       ( new_pulse   ),
        .left_i      ( cap_left    ),
        .right_i     ( cap_right   ),
        .fmt_i       ( cap_fmt     ),
        .cen_o       ( cen         ),
        .pcm_left_o  ( pcm_left    ),
        .pcm_right_o ( pcm_right   )
    );

    snd_sigma_delta u_dsm_left (
        .clk_dac     ( clk_dac     ),
        .rst         ( rst         ),
        .cen_i       ( cen         ),
        .pcm_i       ( pcm_left    ),
        .bit_o       ( bit_left    )
    );

    // Runs in mono too; its bit is simply not routed then
    snd_sigma_delta u_dsm_right (
        .clk_dac     ( clk_dac     ),
        .rst         ( rst         ),
        .cen_i       ( cen         ),
        .pcm_i       ( pcm_right   ),
        .bit_o       ( bit_right   )
    );

    snd_dac_out u_dac_out (
        .clk_dac     ( clk_dac     ),
        .rst         ( rst         ),
        .stereo_i    ( stereo_i    ),
        .bit_left_i  ( bit_left    ),
        .bit_right_i ( bit_right   ),
        .pwm_left_o  ( pwm_left_o  ),
        .pwm_right_o ( pwm_right_o )
    );

endmodule

`default_nettype wire

//--- verification/tb_clk_gen.sv
// Free-running testbench clock, 8 ns period, starts low at time zero
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o
);

    localparam realtime HALF_PERIOD = 4.0;

    initial begin
        clk_o = 1'b0;
    end

    // 125 MHz stand-in for the DAC clock
    always begin
        #(HALF_PERIOD);
        clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

//--- verification/tb_snd_dac.sv
// Testbench for the sound path; densities must land within 8 counts over 4096-cycle windows
`timescale 1ns/1ps
`default_nettype none

module tb_snd_dac;

    import snd_pkg::*;

    localparam int          WIN_UPDATES  = 1024;
    localparam int          WIN_CYCLES   = CEN_DIV * WIN_UPDATES;
    localparam int          SETTLE_CYC   = 8;
    localparam int          TOL_COUNT    = 8;
    localparam int          RST_CYCLES   = 5;
    localparam int          HS_TIMEOUT   = 50;
    localparam int          CHK_TIMEOUT  = WIN_CYCLES + 500;
    localparam int          IDLE_TIMEOUT = 2000;
    localparam int          N_RANDOM     = 20;
    localparam logic [31:0] SEED         = 32'hd68b8aa0;

    logic        clk_dac;
    logic        rst;
    logic        req;
    logic        ack;
    snd_sample_t snd_left;
    snd_sample_t snd_right;
    snd_fmt_e    fmt;
    logic        stereo;
    logic        pwm_left;
    logic        pwm_right;

    // Shared between stimulus and compare process
    int          chk_seq = 0;
    int          done_seq = 0;
    pcm_word_t   exp_left;
    pcm_word_t   exp_right;
    logic        mono_mode;

    int          n_checks = 0;
    int          n_mismatch = 0;
    int          n_timeout = 0;

    tb_clk_gen u_clk_gen (
        .clk_o ( clk_dac )
    );

    snd_dac_top i_dut (
        .clk_dac     ( clk_dac   ),
        .rst         ( rst       ),
        .req_i       ( req       ),
        .ack_o       ( ack       ),
        .snd_left_i  ( snd_left  ),
        .snd_right_i ( snd_right ),
        .fmt_i       ( fmt       ),
        .stereo_i    ( stereo    ),
        .pwm_left_o  ( pwm_left  ),
        .pwm_right_o ( pwm_right )
    );

    // Offset-binary sample scaled by 8 into the 20-bit level
    function automatic pcm_word_t ref_level(input snd_sample_t smp, input snd_fmt_e f);
        int offs;
        if (f == FMT_SIGNED) begin
            offs = int'($signed(smp)) + 32768;
        end else begin
            offs = int'(smp);
        end
        return pcm_word_t'(offs * 8);
    endfunction

    task automatic check_bit(input string what, input logic exp_v, input logic act_v);
        n_checks++;
        if (act_v !== exp_v) begin
            n_mismatch++;
            $display("Mismatch at %0t: %s, expected %b, got %b", $time, what, exp_v, act_v);
        end
    endtask

    // High cycles expected = cycles in window times level over 2^20
    task automatic check_level(input string what, input pcm_word_t exp_lvl, input int count);
        int unsigned prod;
        int          exp_cnt;
        int          diff;
        prod    = 32'(exp_lvl) * CEN_DIV * WIN_UPDATES;
        exp_cnt = int'(prod >> PCM_W);
        diff    = count - exp_cnt;
        n_checks++;
        if (diff > TOL_COUNT || diff < -TOL_COUNT) begin
            n_mismatch++;
            $display("Mismatch at %0t: %s, level %h expects %0d high cycles, counted %0d",
                     $time, what, exp_lvl, exp_cnt, count);
        end
    endtask

    // Four-phase transfer, data set one cycle ahead of req
    task automatic send_pair(input snd_sample_t l_smp, input snd_sample_t r_smp,
                             input snd_fmt_e f);
        int        waited;
        hs_state_e hs_now;
        @(negedge clk_dac);
        snd_left  = l_smp;
        snd_right = r_smp;
        fmt       = f;
        @(negedge clk_dac);
        req    = 1'b1;
        waited = 0;
        while (ack !== 1'b1 && waited < HS_TIMEOUT) begin
            @(negedge clk_dac);
            waited++;
        end
        if (ack !== 1'b1) begin
            n_timeout++;
            hs_now = i_dut.u_sample_in.state_q;
            $display("Timeout at %0t: ack_o never rose after req_i went high, FSM in %s",
                     $time, hs_now.name());
        end
        req    = 1'b0;
        waited = 0;
        while (ack !== 1'b0 && waited < HS_TIMEOUT) begin
            @(negedge clk_dac);
            waited++;
        end
        if (ack !== 1'b0) begin
            n_timeout++;
            hs_now = i_dut.u_sample_in.state_q;
            $display("Timeout at %0t: ack_o never fell after req_i went low, FSM in %s",
                     $time, hs_now.name());
        end
    endtask

    // One transfer followed by one measurement window
    task automatic run_check(input snd_sample_t l_smp, input snd_sample_t r_smp,
                             input snd_fmt_e f, input logic st);
        int waited;
        @(negedge clk_dac);
        stereo = st;
        send_pair(l_smp, r_smp, f);
        exp_left  = ref_level(l_smp, f);
        exp_right = st ? ref_level(r_smp, f) : exp_left;
        mono_mode = !st;
        chk_seq++;
        waited = 0;
        while (done_seq != chk_seq && waited < CHK_TIMEOUT) begin
            @(posedge clk_dac);
            waited++;
        end
        if (done_seq != chk_seq) begin
            n_timeout++;
            $display("Timeout at %0t: measurement window did not complete", $time);
        end
    endtask

    // Compare process, pins sampled on the falling edge
    initial begin : compare_proc
        int idle;
        int cnt_l;
        int cnt_r;
        forever begin
            idle = 0;
            while (chk_seq == done_seq && idle < IDLE_TIMEOUT) begin
                @(posedge clk_dac);
                idle++;
            end
            if (chk_seq == done_seq) begin
                n_timeout++;
                $display("Timeout at %0t: no transfer arrived for the compare process", $time);
            end else begin
                repeat (SETTLE_CYC) @(negedge clk_dac);
                cnt_l = 0;
                cnt_r = 0;
                for (int i = 0; i < WIN_CYCLES; i++) begin
                    @(negedge clk_dac);
                    cnt_l += pwm_left ? 1 : 0;
                    cnt_r += pwm_right ? 1 : 0;
                    if (mono_mode) begin
                        check_bit("pwm_right_o copy of pwm_left_o", pwm_left, pwm_right);
                    end
                end
                check_level("pwm_left_o density", exp_left, cnt_l);
                check_level("pwm_right_o density", exp_right, cnt_r);
                done_seq++;
            end
        end
    end

    initial begin : stimulus
        snd_sample_t r_left;
        snd_sample_t r_right;
        snd_fmt_e    r_fmt;
        logic        r_st;
        rst       = 1'b1;
        req       = 1'b0;
        snd_left  = '0;
        snd_right = '0;
        fmt       = FMT_UNSIGNED;
        stereo    = 1'b1;
        mono_mode = 1'b0;
        exp_left  = '0;
        exp_right = '0;
        void'($urandom(SEED));

        for (int c = 0; c < RST_CYCLES; c++) begin
            @(negedge clk_dac);
            check_bit("ack_o in reset", 1'b0, ack);
            check_bit("pwm_left_o in reset", 1'b0, pwm_left);
            check_bit("pwm_right_o in reset", 1'b0, pwm_right);
        end
        rst = 1'b0;
        repeat (4) begin
            @(negedge clk_dac);
            check_bit("ack_o after reset", 1'b0, ack);
            check_bit("pwm_left_o after reset", 1'b0, pwm_left);
            check_bit("pwm_right_o after reset", 1'b0, pwm_right);
        end

        // Unsigned stereo, including silence and full scale
        run_check(16'h1234, 16'hC000, FMT_UNSIGNED, 1'b1);
        run_check(16'h0000, 16'hFFFF, FMT_UNSIGNED, 1'b1);
        run_check(16'hFFFF, 16'h0000, FMT_UNSIGNED, 1'b1);
        run_check(16'h8000, 16'h4000, FMT_UNSIGNED, 1'b1);

        // Signed zero sits at quarter density, most negative gives silence
        run_check(16'h0000, 16'h8000, FMT_SIGNED, 1'b1);
        run_check(16'h8000, 16'h7FFF, FMT_SIGNED, 1'b1);

        // Mono routing ignores the right sample
        run_check(16'h6000, 16'hFFFF, FMT_UNSIGNED, 1'b0);
        run_check(16'hF000, 16'h0000, FMT_SIGNED, 1'b0);

        for (int k = 0; k < N_RANDOM; k++) begin
            r_left  = snd_sample_t'($urandom());
            r_right = snd_sample_t'($urandom());
            r_fmt   = (($urandom() & 32'd1) != 0) ? FMT_SIGNED : FMT_UNSIGNED;
            r_st    = (($urandom() & 32'd1) != 0);
            run_check(r_left, r_right, r_fmt, r_st);
        end

        $display("Summary: %0d checks, %0d mismatches, %0d timeouts",
                 n_checks, n_mismatch, n_timeout);
        if (n_mismatch == 0 && n_timeout == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
verilog/snd_pkg.sv
verilog/snd_sample_in.sv
verilog/snd_pcm_stage.sv
verilog/snd_sigma_delta.sv
verilog/snd_dac_out.sv
verilog/snd_dac_top.sv
verification/tb_clk_gen.sv
verification/tb_snd_dac.sv

//--- Makefile
# Verilator lint and simulation for the sound output path

VERILATOR ?= verilator
FILELIST  ?= filelist.f
TOP       ?= tb_snd_dac
RTL_TOP   ?= snd_dac_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
JOBS      ?= 0
FAIL_MSG  ?= CHECKS FAILED

SHELL   := /bin/bash
SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	set -o pipefail; ./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
